// ==== design/l15_adapter_pkg.sv ====
/*
 * widths, encodings and packed structs of the L1.5 adapter,
 * plus the 64-bit byte-swap used for the endian conversion
 */
`default_nettype none

package l15_adapter_pkg;

  ////////////////////////////////////////
  // widths and queue depths
  ////////////////////////////////////////

  localparam int PADDR_W         = 40;
  localparam int TID_W           = 2;
  localparam int WAY_W           = 2;
  localparam int REQ_FIFO_DEPTH  = 2;
  localparam int RTRN_FIFO_DEPTH = 2;

  // transaction sizes, 4 bytes for nc ifetch, full line otherwise
  localparam logic [2:0] SIZE_4B   = 3'b010;
  localparam logic [2:0] SIZE_LINE = 3'b111;

  // outgoing request types
  localparam logic [4:0] RQ_LOAD  = 5'b00000;
  localparam logic [4:0] RQ_IMISS = 5'b10000;
  localparam logic [4:0] RQ_STORE = 5'b00001;

  // return types, anything else is dropped by the decoder
  localparam logic [3:0] RET_LOAD   = 4'b0000;
  localparam logic [3:0] RET_IFILL  = 4'b0001;
  localparam logic [3:0] RET_ST_ACK = 4'b0100;

  ////////////////////////////////////////
  // cache side
  ////////////////////////////////////////

  typedef struct packed {
    logic               nc;
    logic [TID_W-1:0]   tid;
    logic [WAY_W-1:0]   way;
    logic [PADDR_W-1:0] paddr;
  } icache_req_t;

  typedef enum logic {DCACHE_LOAD_REQ, DCACHE_STORE_REQ} dcache_rtype_e;

  typedef struct packed {
    dcache_rtype_e      rtype;
    logic               nc;
    logic [2:0]         size;
    logic [TID_W-1:0]   tid;
    logic [WAY_W-1:0]   way;
    logic [PADDR_W-1:0] paddr;
    // little endian, as seen by the core
    logic [63:0]        data;
  } dcache_req_t;

  typedef enum logic {DCACHE_LOAD_ACK, DCACHE_STORE_ACK} dcache_rtrn_kind_e;

  typedef struct packed {
    dcache_rtrn_kind_e kind;
    logic [TID_W-1:0]  tid;
    logic [127:0]      data;
  } dcache_rtrn_t;

  typedef struct packed {
    logic [TID_W-1:0] tid;
    logic [255:0]     data;
  } icache_rtrn_t;

  ////////////////////////////////////////
  // L1.5 side
  ////////////////////////////////////////

  typedef struct packed {
    logic               val;
    logic [4:0]         rqtype;
    logic               nc;
    logic [2:0]         size;
    logic [TID_W-1:0]   threadid;
    logic [WAY_W-1:0]   l1rplway;
    logic [PADDR_W-1:0] address;
    logic [63:0]        data;
    // accepts a return packet
    logic               req_ack;
  } l15_req_t;

  // data words are big endian
  typedef struct packed {
    logic [3:0]       returntype;
    logic [TID_W-1:0] threadid;
    logic [63:0]      data_0;
    logic [63:0]      data_1;
    logic [63:0]      data_2;
    logic [63:0]      data_3;
  } l15_rtrn_data_t;

  typedef struct packed {
    logic           val;
    // accepts a request packet
    logic           ack;
    l15_rtrn_data_t pkt;
  } l15_rtrn_t;

  // reverse the byte order of one 64-bit word
  function automatic logic [63:0] swap_bytes64(input logic [63:0] word);
    logic [63:0] res;
    for (int i = 0; i < 8; i++) begin
      res[8*i +: 8] = word[8*(7-i) +: 8];
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== design/l15_fifo.sv ====
/*
 * first-word-fall-through queue, payload given as a type parameter
 */
`default_nettype none

module l15_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  wire logic     clk_i,
  input  wire logic     rst_i,
  input  wire logic     push_i,
  input  wire payload_t data_i,
  input  wire logic     pop_i,
  output payload_t      data_o,
  output logic          full_o,
  output logic          empty_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q, cnt_d;
  logic             full_q, empty_q;
  logic             do_push, do_pop;

  // overflow and underflow are ignored
  assign do_push = push_i & ~full_q;
  assign do_pop  = pop_i & ~empty_q;

  // occupancy after this cycle
  always_comb begin
    cnt_d = cnt_q;
    if (do_push && !do_pop) begin
      cnt_d = cnt_q + CNT_W'(1);
    end else if (do_pop && !do_push) begin
      cnt_d = cnt_q - CNT_W'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end else begin
      // pointers wrap at DEPTH, which need not be a power of two
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      cnt_q   <= cnt_d;
      full_q  <= (cnt_d == CNT_W'(DEPTH));
      empty_q <= (cnt_d == '0);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // head is visible without a pop
  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = full_q;
  assign empty_o = empty_q;

endmodule

`default_nettype wire

// ==== design/l15_rr_arbiter.sv ====
/*
 * two-way round-robin arbiter, grant held until acknowledge
 */
`default_nettype none

module l15_rr_arbiter (
  input  wire logic       clk_i,
  input  wire logic       rst_i,
  input  wire logic [1:0] req_i,
  input  wire logic       ack_i,
  output logic            gnt_idx_o,
  output logic [1:0]      gnt_o
);

  // prio_q names the requester that wins a tie
  logic prio_q;
  // lock_q holds the grant on lock_idx_q while the L1.5 stalls
  logic lock_q;
  logic lock_idx_q;
  logic idx;
  logic gnt_vld;

  ////////////////////////////////////////
  // grant selection
  ////////////////////////////////////////

  always_comb begin
    if (lock_q) begin
      idx = lock_idx_q;
    end else if (&req_i) begin
      idx = prio_q;
    end else begin
      // single or no requester
      idx = req_i[1];
    end
    gnt_vld = req_i[idx];
  end

  assign gnt_idx_o = idx;
  // pop strobe, one-hot and only on ack
  assign gnt_o = (gnt_vld && ack_i) ? (2'b01 << idx) : 2'b00;

  ////////////////////////////////////////
  // priority and lock state
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q     <= 1'b0;
      lock_q     <= 1'b0;
      lock_idx_q <= 1'b0;
    end else if (gnt_vld) begin
      if (ack_i) begin
        // served, hand the tie to the other side
        lock_q <= 1'b0;
        prio_q <= ~idx;
      end else begin
        // stalled, keep the packet stable
        lock_q     <= 1'b1;
        lock_idx_q <= idx;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/l15_req_encoder.sv ====
/*
 * builds the outgoing L1.5 request from the granted queue head
 */
`default_nettype none

module l15_req_encoder (
  input  wire logic                        any_req_i,
  input  wire logic                        gnt_idx_i,
  input  wire l15_adapter_pkg::icache_req_t icache_data_i,
  input  wire l15_adapter_pkg::dcache_req_t dcache_data_i,
  output l15_adapter_pkg::l15_req_t         l15_req_o
);

  always_comb begin
    // unused fields stay zero, req_ack is filled in by the return path
    l15_req_o     = '0;
    l15_req_o.val = any_req_i;

    if (gnt_idx_i) begin
      ////////////////////////////////////////
      // data cache
      ////////////////////////////////////////
      if (dcache_data_i.rtype == l15_adapter_pkg::DCACHE_STORE_REQ) begin
        l15_req_o.rqtype = l15_adapter_pkg::RQ_STORE;
      end else begin
        l15_req_o.rqtype = l15_adapter_pkg::RQ_LOAD;
      end
      l15_req_o.nc       = dcache_data_i.nc;
      // size comes straight from the cache
      l15_req_o.size     = dcache_data_i.size;
      l15_req_o.threadid = dcache_data_i.tid;
      l15_req_o.l1rplway = dcache_data_i.way;
      l15_req_o.address  = dcache_data_i.paddr;
      // core is little endian, L1.5 is big endian
      l15_req_o.data     = l15_adapter_pkg::swap_bytes64(dcache_data_i.data);
    end else begin
      ////////////////////////////////////////
      // instruction cache
      ////////////////////////////////////////
      l15_req_o.rqtype   = l15_adapter_pkg::RQ_IMISS;
      l15_req_o.nc       = icache_data_i.nc;
      // nc fetches go to I/O space and return a single word
      if (icache_data_i.nc) begin
        l15_req_o.size = l15_adapter_pkg::SIZE_4B;
      end else begin
        l15_req_o.size = l15_adapter_pkg::SIZE_LINE;
      end
      l15_req_o.threadid = icache_data_i.tid;
      l15_req_o.l1rplway = icache_data_i.way;
      l15_req_o.address  = icache_data_i.paddr;
    end
  end

endmodule

`default_nettype wire

// ==== design/l15_rtrn_decoder.sv ====
/*
 * decodes the head of the return queue into icache or dcache returns
 */
`default_nettype none

module l15_rtrn_decoder (
  input  wire logic                           valid_i,
  input  wire l15_adapter_pkg::l15_rtrn_data_t pkt_i,
  output logic                                icache_rtrn_vld_o,
  output l15_adapter_pkg::icache_rtrn_t        icache_rtrn_o,
  output logic                                dcache_rtrn_vld_o,
  output l15_adapter_pkg::dcache_rtrn_t        dcache_rtrn_o
);

  ////////////////////////////////////////
  // return type
  ////////////////////////////////////////

  always_comb begin
    icache_rtrn_vld_o  = 1'b0;
    dcache_rtrn_vld_o  = 1'b0;
    dcache_rtrn_o.kind = l15_adapter_pkg::DCACHE_LOAD_ACK;
    if (valid_i) begin
      case (pkt_i.returntype)
        l15_adapter_pkg::RET_LOAD: begin
          dcache_rtrn_vld_o = 1'b1;
        end
        l15_adapter_pkg::RET_ST_ACK: begin
          dcache_rtrn_o.kind = l15_adapter_pkg::DCACHE_STORE_ACK;
          dcache_rtrn_vld_o  = 1'b1;
        end
        l15_adapter_pkg::RET_IFILL: begin
          icache_rtrn_vld_o = 1'b1;
        end
        // unsupported types are consumed silently
        default: begin
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // payload, big to little endian
  ////////////////////////////////////////

  // thread id doubles as transaction id
  assign dcache_rtrn_o.tid = pkt_i.threadid;
  assign icache_rtrn_o.tid = pkt_i.threadid;

  // dcache sees the lower 128 bits only
  assign dcache_rtrn_o.data = {
    l15_adapter_pkg::swap_bytes64(pkt_i.data_1),
    l15_adapter_pkg::swap_bytes64(pkt_i.data_0)
  };

  // full line for the icache
  assign icache_rtrn_o.data = {
    l15_adapter_pkg::swap_bytes64(pkt_i.data_3),
    l15_adapter_pkg::swap_bytes64(pkt_i.data_2),
    l15_adapter_pkg::swap_bytes64(pkt_i.data_1),
    l15_adapter_pkg::swap_bytes64(pkt_i.data_0)
  };

endmodule

`default_nettype wire

// ==== design/l15_adapter.sv ====
/*
 * L1.5 adapter top, request queues with round-robin arbitration
 * toward the L1.5 and a return queue decoded back to the caches
 */
`default_nettype none

module l15_adapter (
  input  wire logic                          clk_i,
  input  wire logic                          rst_i,
  // instruction cache
  input  wire logic                          icache_req_i,
  input  wire l15_adapter_pkg::icache_req_t  icache_data_i,
  output logic                               icache_ack_o,
  // data cache
  input  wire logic                          dcache_req_i,
  input  wire l15_adapter_pkg::dcache_req_t  dcache_data_i,
  output logic                               dcache_ack_o,
  // returns, taken by the caches at once
  output logic                               icache_rtrn_vld_o,
  output l15_adapter_pkg::icache_rtrn_t      icache_rtrn_o,
  output logic                               dcache_rtrn_vld_o,
  output l15_adapter_pkg::dcache_rtrn_t      dcache_rtrn_o,
  // L1.5
  output l15_adapter_pkg::l15_req_t          l15_req_o,
  input  wire l15_adapter_pkg::l15_rtrn_t    l15_rtrn_i
);

  l15_adapter_pkg::icache_req_t    icache_head;
  l15_adapter_pkg::dcache_req_t    dcache_head;
  l15_adapter_pkg::l15_req_t       enc_req;
  l15_adapter_pkg::l15_rtrn_data_t rtrn_head;
  logic       icache_full, icache_empty;
  logic       dcache_full, dcache_empty;
  logic       rtrn_full, rtrn_empty;
  logic       rtrn_ack;
  logic [1:0] arb_req, arb_pop;
  logic       arb_idx;

  ////////////////////////////////////////
  // request path
  ////////////////////////////////////////

  assign icache_ack_o = icache_req_i & ~icache_full;
  assign dcache_ack_o = dcache_req_i & ~dcache_full;

  l15_fifo #(
    .payload_t (l15_adapter_pkg::icache_req_t),
    .DEPTH     (l15_adapter_pkg::REQ_FIFO_DEPTH)
  ) u_icache_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (icache_ack_o),
    .data_i  (icache_data_i),
    .pop_i   (arb_pop[0]),
    .data_o  (icache_head),
    .full_o  (icache_full),
    .empty_o (icache_empty)
  );

  l15_fifo #(
    .payload_t (l15_adapter_pkg::dcache_req_t),
    .DEPTH     (l15_adapter_pkg::REQ_FIFO_DEPTH)
  ) u_dcache_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (dcache_ack_o),
    .data_i  (dcache_data_i),
    .pop_i   (arb_pop[1]),
    .data_o  (dcache_head),
    .full_o  (dcache_full),
    .empty_o (dcache_empty)
  );

  // bit 0 icache, bit 1 dcache
  assign arb_req = {~dcache_empty, ~icache_empty};

  l15_rr_arbiter u_arbiter (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (arb_req),
    .ack_i     (l15_rtrn_i.ack),
    .gnt_idx_o (arb_idx),
    .gnt_o     (arb_pop)
  );

  l15_req_encoder u_encoder (
    .any_req_i     (|arb_req),
    .gnt_idx_i     (arb_idx),
    .icache_data_i (icache_head),
    .dcache_data_i (dcache_head),
    .l15_req_o     (enc_req)
  );

  always_comb begin
    l15_req_o         = enc_req;
    l15_req_o.req_ack = rtrn_ack;
  end

  ////////////////////////////////////////
  // return path
  ////////////////////////////////////////

  // queue drains every cycle, so this never drops
  assign rtrn_ack = l15_rtrn_i.val & ~rtrn_full;

  l15_fifo #(
    .payload_t (l15_adapter_pkg::l15_rtrn_data_t),
    .DEPTH     (l15_adapter_pkg::RTRN_FIFO_DEPTH)
  ) u_rtrn_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (rtrn_ack),
    .data_i  (l15_rtrn_i.pkt),
    .pop_i   (~rtrn_empty),
    .data_o  (rtrn_head),
    .full_o  (rtrn_full),
    .empty_o (rtrn_empty)
  );

  l15_rtrn_decoder u_decoder (
    .valid_i           (~rtrn_empty),
    .pkt_i             (rtrn_head),
    .icache_rtrn_vld_o (icache_rtrn_vld_o),
    .icache_rtrn_o     (icache_rtrn_o),
    .dcache_rtrn_vld_o (dcache_rtrn_vld_o),
    .dcache_rtrn_o     (dcache_rtrn_o)
  );

endmodule

`default_nettype wire

// ==== dv/tb_l15_adapter.sv ====
/*
 * testbench for the L1.5 adapter, random cache requests, L1.5 stalls
 * and return beats checked against a queue-based reference model
 */
`default_nettype none

module tb_l15_adapter;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int SEED         = 15;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int N_ICACHE     = 32;
  localparam int N_DCACHE     = 32;
  localparam int N_RTRN       = 40;
  // L1.5 ack held low over this window of cycles
  localparam int STALL_START  = 40;
  localparam int STALL_END    = 56;
  localparam int WATCHDOG_NS  = (N_ICACHE + N_DCACHE + N_RTRN) * 50 * CLK_PERIOD;

  logic clk_i;
  logic rst_i;
  logic icache_req_i;
  logic icache_ack_o;
  logic dcache_req_i;
  logic dcache_ack_o;
  logic icache_rtrn_vld_o;
  logic dcache_rtrn_vld_o;
  logic l15_val;
  logic l15_ack;
  l15_adapter_pkg::icache_req_t    icache_data_i;
  l15_adapter_pkg::dcache_req_t    dcache_data_i;
  l15_adapter_pkg::icache_rtrn_t   icache_rtrn_o;
  l15_adapter_pkg::dcache_rtrn_t   dcache_rtrn_o;
  l15_adapter_pkg::l15_req_t       l15_req_o;
  l15_adapter_pkg::l15_rtrn_data_t l15_pkt;
  l15_adapter_pkg::l15_rtrn_t      l15_rtrn_i;

  // reference model state
  l15_adapter_pkg::icache_req_t    icache_q[$];
  l15_adapter_pkg::dcache_req_t    dcache_q[$];
  l15_adapter_pkg::l15_req_t       prev_pkt;
  l15_adapter_pkg::l15_rtrn_data_t exp_beat;
  logic prev_stall;
  logic both_pend;
  logic have_last;
  logic last_src;
  logic exp_beat_vld;
  logic icache_done;
  logic dcache_done;
  int   n_checks;
  int   n_errors;
  int   n_isent;
  int   n_dsent;

  assign l15_rtrn_i = '{val: l15_val, ack: l15_ack, pkt: l15_pkt};

  l15_adapter UUT (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .icache_req_i      (icache_req_i),
    .icache_data_i     (icache_data_i),
    .icache_ack_o      (icache_ack_o),
    .dcache_req_i      (dcache_req_i),
    .dcache_data_i     (dcache_data_i),
    .dcache_ack_o      (dcache_ack_o),
    .icache_rtrn_vld_o (icache_rtrn_vld_o),
    .icache_rtrn_o     (icache_rtrn_o),
    .dcache_rtrn_vld_o (dcache_rtrn_vld_o),
    .dcache_rtrn_o     (dcache_rtrn_o),
    .l15_req_o         (l15_req_o),
    .l15_rtrn_i        (l15_rtrn_i)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // little/big endian swap of one double word
  function automatic logic [63:0] flip_endian(input logic [63:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24], w[39:32], w[47:40], w[55:48], w[63:56]};
  endfunction

  // mostly the three decoded types, now and then an unknown one
  function automatic logic [3:0] pick_return_type();
    logic [3:0] t;
    int         sel;
    sel = $urandom_range(0, 9);
    if (sel < 3) begin
      t = l15_adapter_pkg::RET_LOAD;
    end else if (sel < 5) begin
      t = l15_adapter_pkg::RET_ST_ACK;
    end else if (sel < 8) begin
      t = l15_adapter_pkg::RET_IFILL;
    end else begin
      t = 4'($urandom_range(0, 15));
      while (t == l15_adapter_pkg::RET_LOAD || t == l15_adapter_pkg::RET_ST_ACK ||
             t == l15_adapter_pkg::RET_IFILL) begin
        t = 4'($urandom_range(0, 15));
      end
    end
    return t;
  endfunction

  task automatic report_mismatch(input string sig, input logic [263:0] got,
                                 input logic [263:0] exp);
    $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", sig, got, exp, $time);
    n_errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s at %0t", msg, $time);
    n_errors++;
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic drive_icache();
    l15_adapter_pkg::icache_req_t req;
    logic [63:0] addr;
    logic [31:0] rnd;
    for (int k = 0; k < N_ICACHE; k++) begin
      repeat ($urandom_range(0, 2)) begin
        @(posedge clk_i);
        #2;
      end
      rnd       = $urandom;
      addr      = {$urandom, $urandom};
      req.nc    = rnd[0];
      req.tid   = rnd[2:1];
      req.way   = rnd[4:3];
      req.paddr = addr[l15_adapter_pkg::PADDR_W-1:0];
      icache_data_i = req;
      icache_req_i  = 1'b1;
      // hold until the queue takes it
      @(negedge clk_i);
      while (!icache_ack_o) @(negedge clk_i);
      @(posedge clk_i);
      #2;
      icache_req_i = 1'b0;
    end
    icache_done = 1'b1;
  endtask

  task automatic drive_dcache();
    l15_adapter_pkg::dcache_req_t req;
    logic [63:0] addr;
    logic [31:0] rnd;
    for (int k = 0; k < N_DCACHE; k++) begin
      repeat ($urandom_range(0, 2)) begin
        @(posedge clk_i);
        #2;
      end
      rnd       = $urandom;
      addr      = {$urandom, $urandom};
      req.rtype = l15_adapter_pkg::dcache_rtype_e'(rnd[0]);
      req.nc    = rnd[1];
      req.size  = rnd[4:2];
      req.tid   = rnd[6:5];
      req.way   = rnd[8:7];
      req.paddr = addr[l15_adapter_pkg::PADDR_W-1:0];
      req.data  = {$urandom, $urandom};
      dcache_data_i = req;
      dcache_req_i  = 1'b1;
      @(negedge clk_i);
      while (!dcache_ack_o) @(negedge clk_i);
      @(posedge clk_i);
      #2;
      dcache_req_i = 1'b0;
    end
    dcache_done = 1'b1;
  endtask

  // random acks with a long stall in the middle, stops once the DUT is drained
  task automatic drive_l15_ack();
    int cyc;
    cyc = 0;
    while (1) begin
      @(posedge clk_i);
      #2;
      if (cyc == STALL_END) begin
        // both request queues must have filled during the stall
        n_checks++;
        if (!icache_done && icache_q.size() != l15_adapter_pkg::REQ_FIFO_DEPTH) begin
          report_failure("icache queue did not fill while the L1.5 stalled");
        end
        if (!dcache_done && dcache_q.size() != l15_adapter_pkg::REQ_FIFO_DEPTH) begin
          report_failure("dcache queue did not fill while the L1.5 stalled");
        end
      end
      if (cyc >= STALL_END && icache_done && dcache_done && !l15_req_o.val) begin
        break;
      end
      if (cyc >= STALL_START && cyc < STALL_END) begin
        l15_ack = 1'b0;
      end else begin
        l15_ack = ($urandom_range(0, 3) != 0);
      end
      cyc++;
    end
    l15_ack = 1'b0;
  endtask

  // return beats go back to back when the gap is zero
  task automatic drive_returns();
    l15_adapter_pkg::l15_rtrn_data_t beat;
    logic [31:0] rnd;
    for (int k = 0; k < N_RTRN; k++) begin
      rnd             = $urandom;
      beat.returntype = pick_return_type();
      beat.threadid   = rnd[1:0];
      beat.data_0     = {$urandom, $urandom};
      beat.data_1     = {$urandom, $urandom};
      beat.data_2     = {$urandom, $urandom};
      beat.data_3     = {$urandom, $urandom};
      l15_pkt = beat;
      l15_val = 1'b1;
      @(negedge clk_i);
      while (!l15_req_o.req_ack) @(negedge clk_i);
      @(posedge clk_i);
      #2;
      l15_val = 1'b0;
      repeat ($urandom_range(0, 2)) begin
        @(posedge clk_i);
        #2;
      end
    end
  endtask

  ////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////

  // sampled mid-cycle while inputs and outputs are settled
  always @(negedge clk_i) begin : monitor
    l15_adapter_pkg::l15_req_t     pkt;
    l15_adapter_pkg::icache_req_t  ireq;
    l15_adapter_pkg::dcache_req_t  dreq;
    l15_adapter_pkg::dcache_rtrn_t exp_d;
    l15_adapter_pkg::icache_rtrn_t exp_i;
    logic [4:0] exp_type;
    logic       src;
    logic       exp_ivld;
    logic       exp_dvld;
    if (rst_i) begin
      prev_stall   = 1'b0;
      have_last    = 1'b0;
      both_pend    = 1'b0;
      exp_beat_vld = 1'b0;
    end else begin
      // cache acks follow the queue occupancy
      n_checks++;
      if (icache_ack_o !== (icache_req_i &&
                            icache_q.size() < l15_adapter_pkg::REQ_FIFO_DEPTH)) begin
        report_mismatch("icache_ack_o", icache_ack_o, ~icache_ack_o);
      end
      if (dcache_ack_o !== (dcache_req_i &&
                            dcache_q.size() < l15_adapter_pkg::REQ_FIFO_DEPTH)) begin
        report_mismatch("dcache_ack_o", dcache_ack_o, ~dcache_ack_o);
      end

      // L1.5 request with req_ack masked off
      pkt         = l15_req_o;
      pkt.req_ack = 1'b0;
      if (l15_req_o.val !== (icache_q.size() != 0 || dcache_q.size() != 0)) begin
        report_mismatch("l15_req_o.val", l15_req_o.val, ~l15_req_o.val);
      end
      if (prev_stall && pkt !== prev_pkt) begin
        report_mismatch("l15_req_o (stalled)", pkt, prev_pkt);
      end
      // tie state as seen when the grant is decided
      if (l15_req_o.val && !prev_stall) begin
        both_pend = (icache_q.size() != 0 && dcache_q.size() != 0);
      end
      if (l15_req_o.val && l15_ack) begin
        n_checks++;
        src = (l15_req_o.rqtype != l15_adapter_pkg::RQ_IMISS);
        if (!src) begin
          if (icache_q.size() == 0) begin
            report_failure("icache packet sent with no icache request pending");
          end else begin
            ireq = icache_q.pop_front();
            n_isent++;
            if ({pkt.rqtype, pkt.nc, pkt.size, pkt.threadid, pkt.l1rplway, pkt.address} !==
                {l15_adapter_pkg::RQ_IMISS, ireq.nc,
                 ireq.nc ? l15_adapter_pkg::SIZE_4B : l15_adapter_pkg::SIZE_LINE,
                 ireq.tid, ireq.way, ireq.paddr}) begin
              report_mismatch("l15_req_o (icache)",
                              {pkt.rqtype, pkt.nc, pkt.size, pkt.threadid, pkt.l1rplway,
                               pkt.address},
                              {l15_adapter_pkg::RQ_IMISS, ireq.nc,
                               ireq.nc ? l15_adapter_pkg::SIZE_4B : l15_adapter_pkg::SIZE_LINE,
                               ireq.tid, ireq.way, ireq.paddr});
            end
          end
        end else begin
          if (dcache_q.size() == 0) begin
            report_failure("dcache packet sent with no dcache request pending");
          end else begin
            dreq = dcache_q.pop_front();
            n_dsent++;
            exp_type = (dreq.rtype == l15_adapter_pkg::DCACHE_STORE_REQ) ?
                       l15_adapter_pkg::RQ_STORE : l15_adapter_pkg::RQ_LOAD;
            if ({pkt.rqtype, pkt.nc, pkt.size, pkt.threadid, pkt.l1rplway, pkt.address,
                 pkt.data} !== {exp_type, dreq.nc, dreq.size, dreq.tid, dreq.way,
                                dreq.paddr, flip_endian(dreq.data)}) begin
              report_mismatch("l15_req_o (dcache)",
                              {pkt.rqtype, pkt.nc, pkt.size, pkt.threadid, pkt.l1rplway,
                               pkt.address, pkt.data},
                              {exp_type, dreq.nc, dreq.size, dreq.tid, dreq.way,
                               dreq.paddr, flip_endian(dreq.data)});
            end
          end
        end
        // round robin under contention
        if (both_pend && have_last && src == last_src) begin
          report_failure("arbiter served the same cache twice while both queues held requests");
        end
        last_src  = src;
        have_last = 1'b1;
      end
      prev_stall = l15_req_o.val && !l15_ack;
      prev_pkt   = pkt;

      // accepted requests enter the model after the send side
      if (icache_req_i && icache_ack_o) begin
        icache_q.push_back(icache_data_i);
      end
      if (dcache_req_i && dcache_ack_o) begin
        dcache_q.push_back(dcache_data_i);
      end

      // return path decodes one cycle after acceptance
      n_checks++;
      if (l15_req_o.req_ack !== l15_val) begin
        report_mismatch("l15_req_o.req_ack", l15_req_o.req_ack, l15_val);
      end
      exp_ivld = exp_beat_vld && exp_beat.returntype == l15_adapter_pkg::RET_IFILL;
      exp_dvld = exp_beat_vld && (exp_beat.returntype == l15_adapter_pkg::RET_LOAD ||
                                  exp_beat.returntype == l15_adapter_pkg::RET_ST_ACK);
      if (icache_rtrn_vld_o !== exp_ivld) begin
        report_mismatch("icache_rtrn_vld_o", icache_rtrn_vld_o, exp_ivld);
      end
      if (dcache_rtrn_vld_o !== exp_dvld) begin
        report_mismatch("dcache_rtrn_vld_o", dcache_rtrn_vld_o, exp_dvld);
      end
      if (exp_dvld) begin
        exp_d.kind = (exp_beat.returntype == l15_adapter_pkg::RET_ST_ACK) ?
                     l15_adapter_pkg::DCACHE_STORE_ACK : l15_adapter_pkg::DCACHE_LOAD_ACK;
        exp_d.tid  = exp_beat.threadid;
        exp_d.data = {flip_endian(exp_beat.data_1), flip_endian(exp_beat.data_0)};
        if (dcache_rtrn_o !== exp_d) begin
          report_mismatch("dcache_rtrn_o", dcache_rtrn_o, exp_d);
        end
      end
      if (exp_ivld) begin
        exp_i.tid  = exp_beat.threadid;
        exp_i.data = {flip_endian(exp_beat.data_3), flip_endian(exp_beat.data_2),
                      flip_endian(exp_beat.data_1), flip_endian(exp_beat.data_0)};
        if (icache_rtrn_o !== exp_i) begin
          report_mismatch("icache_rtrn_o", icache_rtrn_o, exp_i);
        end
      end
      exp_beat_vld = l15_val && l15_req_o.req_ack;
      exp_beat     = l15_pkt;
    end
  end

  ////////////////////////////////////////
  // run control
  ////////////////////////////////////////

  initial begin : main
    void'($urandom(SEED));
    clk_i         = 1'b0;
    rst_i         = 1'b1;
    icache_req_i  = 1'b0;
    icache_data_i = '0;
    dcache_req_i  = 1'b0;
    dcache_data_i = '0;
    l15_val       = 1'b0;
    l15_ack       = 1'b0;
    l15_pkt       = '0;
    icache_done   = 1'b0;
    dcache_done   = 1'b0;
    n_checks      = 0;
    n_errors      = 0;
    n_isent       = 0;
    n_dsent       = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    // forked drivers draw from the seeded generator
    fork
      drive_icache();
      drive_dcache();
      drive_l15_ack();
      drive_returns();
    join
    repeat (3) @(posedge clk_i);
    n_checks++;
    if (n_isent != N_ICACHE || n_dsent != N_DCACHE) begin
      report_failure("not every accepted cache request reached the L1.5");
    end
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/l15_adapter_pkg.sv
design/l15_fifo.sv
design/l15_rr_arbiter.sv
design/l15_req_encoder.sv
design/l15_rtrn_decoder.sv
design/l15_adapter.sv
dv/tb_l15_adapter.sv
